// ==== all.f ====
rtl/pic_pkg.sv
rtl/pic_gateway.sv
rtl/pic_regs.sv
rtl/pic_arbiter.sv
rtl/pic_notify.sv
rtl/pic_top.sv
testbench/pic_tb_assert.sv
testbench/pic_tb.sv

// ==== testbench/pic_tb.sv ====
// Testbench for the interrupt controller
// Clock, reset, stimulus table with expected values
// Value checker, watchdog and closing report

`timescale 1ns/1ns

module pic_tb;

   typedef enum logic [1:0] {STEP_WR, STEP_RD, STEP_IRQ} step_kind_e;

   // Unused fields of a table row stay zero
   typedef struct packed {
      step_kind_e                  kind;
      logic [31:0]                 addr;
      logic [31:0]                 data;   // Write data or expected read data
      logic [pic_pkg::NUM_SRC-1:0] req;
      pic_pkg::pic_core_state_t    core;
      pic_pkg::pic_claim_t         claim;  // Expected claim
      logic                        pend;
      logic                        wake;
   } step_t;

   logic                        clk;
   logic                        rst_n;
   logic [pic_pkg::NUM_SRC-1:0] extintsrc_req;
   pic_pkg::pic_bus_req_t       bus_req;
   pic_pkg::pic_core_state_t    core_state;
   logic [31:0]                 picm_rd_data;
   pic_pkg::pic_claim_t         claim;
   logic                        mexintpend;
   logic                        mhwakeup;

   step_t steps[$];
   logic  table_ready;
   int    errors;
   int    checks;
   int    cur_step;

   pic_top pic_top_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .extintsrc_req (extintsrc_req),
      .bus_req       (bus_req),
      .core_state    (core_state),
      .picm_rd_data  (picm_rd_data),
      .claim         (claim),
      .mexintpend    (mexintpend),
      .mhwakeup      (mhwakeup)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;  // 100 ns period
   end

   function automatic logic [31:0] reg_addr(input logic [2:0] region, input logic [3:0] idx);
      return {pic_pkg::PIC_BASE_PAGE, region, 6'b0, idx, 2'b00};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR: %s = 0x%0h, expected 0x%0h at step %0d", name, got, exp, cur_step);
      end
   endtask

   ////////////////////
   // Table rows
   ////////////////////
   task automatic write_step(input logic [31:0] addr, input logic [31:0] data);
      step_t s;
      s = '0;
      s.kind = STEP_WR;
      s.addr = addr;
      s.data = data;
      steps.push_back(s);
   endtask

   task automatic read_step(input logic [31:0] addr, input logic [31:0] exp);
      step_t s;
      s = '0;
      s.kind = STEP_RD;
      s.addr = addr;
      s.data = exp;
      steps.push_back(s);
   endtask

   task automatic irq_step(input logic [15:0] req, input logic [3:0] thresh,
                           input logic [3:0] curpl, input logic [7:0] id,
                           input logic [3:0] level, input logic pend, input logic wake);
      step_t s;
      s = '0;
      s.kind        = STEP_IRQ;
      s.req         = req;
      s.core.thresh = thresh;
      s.core.curpl  = curpl;
      s.claim.id    = id;
      s.claim.level = level;
      s.pend        = pend;
      s.wake        = wake;
      steps.push_back(s);
   endtask

   task automatic build_table();
      // Register access
      write_step(reg_addr(pic_pkg::REG_PRIORITY, 4'd1), 32'h5);
      read_step(reg_addr(pic_pkg::REG_PRIORITY, 4'd1), 32'h5);
      write_step(reg_addr(pic_pkg::REG_PRIORITY, 4'd2), 32'ha);
      write_step(reg_addr(pic_pkg::REG_PRIORITY, 4'd3), 32'ha);
      write_step(reg_addr(pic_pkg::REG_PRIORITY, 4'd4), 32'hf);
      write_step(reg_addr(pic_pkg::REG_PRIORITY, 4'd5), 32'h3);
      write_step(reg_addr(pic_pkg::REG_PRIORITY, 4'd6), 32'hc);
      write_step(reg_addr(pic_pkg::REG_PRIORITY, 4'd9), 32'he);
      write_step(reg_addr(pic_pkg::REG_PRIORITY, 4'd7), 32'hffff_fff7);
      read_step(reg_addr(pic_pkg::REG_PRIORITY, 4'd7), 32'h7);      // Upper bits dropped
      write_step(reg_addr(pic_pkg::REG_PRIORITY, 4'd0), 32'hf);
      read_step(reg_addr(pic_pkg::REG_PRIORITY, 4'd0), 32'h0);      // ID 0 reserved
      for (int i = 1; i <= 5; i++) begin
         write_step(reg_addr(pic_pkg::REG_ENABLE, 4'(i)), 32'h1);
      end
      write_step(reg_addr(pic_pkg::REG_ENABLE, 4'd9), 32'h1);
      read_step(reg_addr(pic_pkg::REG_ENABLE, 4'd2), 32'h1);
      read_step(reg_addr(pic_pkg::REG_ENABLE, 4'd6), 32'h0);
      write_step(reg_addr(pic_pkg::REG_GW_CONFIG, 4'd10), 32'h2);
      read_step(reg_addr(pic_pkg::REG_GW_CONFIG, 4'd10), 32'h2);
      read_step(reg_addr(3'd6, 4'd1), 32'h0);                        // Unmapped region
      read_step(32'hf00d_0004, 32'h0);                               // Outside the window
      read_step(reg_addr(pic_pkg::REG_PRIORITY, 4'd1) | 32'h100, 32'h0);
      read_step(pic_pkg::PIC_CONFIG_ADDR, 32'h0);

      // Arbitration with a tie and a disabled source
      irq_step(16'h000e, 4'h0, 4'h0, 8'd2, 4'ha, 1'b1, 1'b0);
      irq_step(16'h004e, 4'h0, 4'h0, 8'd2, 4'ha, 1'b1, 1'b0);
      irq_step(16'h005e, 4'h0, 4'h0, 8'd4, 4'hf, 1'b1, 1'b1);

      // Threshold and current level
      irq_step(16'h000e, 4'ha, 4'h0, 8'd2, 4'ha, 1'b0, 1'b0);
      irq_step(16'h000e, 4'h9, 4'ha, 8'd2, 4'ha, 1'b0, 1'b0);
      irq_step(16'h000e, 4'h9, 4'h9, 8'd2, 4'ha, 1'b1, 1'b0);
      irq_step(16'h0000, 4'h0, 4'h0, 8'd0, 4'h0, 1'b0, 1'b0);

      // Active low source and pending vector
      write_step(reg_addr(pic_pkg::REG_GW_CONFIG, 4'd5), 32'h1);
      irq_step(16'h0000, 4'h0, 4'h0, 8'd5, 4'h3, 1'b1, 1'b0);
      read_step(reg_addr(pic_pkg::REG_PENDING, 4'd0), 32'h20);
      irq_step(16'h0065, 4'h0, 4'h0, 8'd2, 4'ha, 1'b1, 1'b0);
      read_step(reg_addr(pic_pkg::REG_PENDING, 4'd0), 32'h44);

      // Latched source 9 held until its clear
      write_step(reg_addr(pic_pkg::REG_GW_CONFIG, 4'd9), 32'h2);
      irq_step(16'h0220, 4'h0, 4'h0, 8'd9, 4'he, 1'b1, 1'b0);
      irq_step(16'h0020, 4'h0, 4'h0, 8'd9, 4'he, 1'b1, 1'b0);
      read_step(reg_addr(pic_pkg::REG_PENDING, 4'd0), 32'h200);
      write_step(reg_addr(pic_pkg::REG_GW_CLEAR, 4'd9), 32'h0);
      irq_step(16'h0020, 4'h0, 4'h0, 8'd0, 4'h0, 1'b0, 1'b0);
      read_step(reg_addr(pic_pkg::REG_PENDING, 4'd0), 32'h0);

      // Reversed order with 0 most urgent
      write_step(pic_pkg::PIC_CONFIG_ADDR, 32'h1);
      read_step(pic_pkg::PIC_CONFIG_ADDR, 32'h1);
      irq_step(16'h0026, 4'hf, 4'hf, 8'd1, 4'h5, 1'b1, 1'b0);
      irq_step(16'h0026, 4'h5, 4'hf, 8'd1, 4'h5, 1'b0, 1'b0);
      irq_step(16'h0026, 4'h6, 4'h6, 8'd1, 4'h5, 1'b1, 1'b0);
      write_step(reg_addr(pic_pkg::REG_PRIORITY, 4'd3), 32'h0);
      irq_step(16'h002e, 4'hf, 4'hf, 8'd3, 4'h0, 1'b1, 1'b1);
      irq_step(16'h0020, 4'hf, 4'hf, 8'd0, 4'hf, 1'b0, 1'b0);     // Idle level reads 15
   endtask

   ////////////////////
   // Step driver
   ////////////////////
   task automatic apply_step(input step_t s);
      case (s.kind)
         STEP_WR: begin
            bus_req.wr_en   = 1'b1;
            bus_req.wr_addr = s.addr;
            bus_req.wr_data = s.data;
            @(posedge clk);
            #10;
            bus_req.wr_en = 1'b0;
         end
         STEP_RD: begin
            bus_req.rd_en   = 1'b1;
            bus_req.rd_addr = s.addr;
            @(posedge clk);
            #10;
            bus_req.rd_en = 1'b0;
            check_value("picm_rd_data", picm_rd_data, s.data);  // Valid in this cycle
         end
         default: begin
            extintsrc_req = s.req;
            core_state    = s.core;
            repeat (4) @(posedge clk);  // Synchronizer and notify registers
            #10;
            check_value("claim.id", 32'(claim.id), 32'(s.claim.id));
            check_value("claim.level", 32'(claim.level), 32'(s.claim.level));
            check_value("mexintpend", 32'(mexintpend), 32'(s.pend));
            check_value("mhwakeup", 32'(mhwakeup), 32'(s.wake));
         end
      endcase
   endtask

   initial begin
      rst_n         = 1'b0;
      extintsrc_req = '0;
      bus_req       = '0;
      core_state    = '0;
      errors        = 0;
      checks        = 0;
      cur_step      = -1;
      table_ready   = 1'b0;
      build_table();
      table_ready = 1'b1;

      // A read held during reset must not reach picm_rd_data
      bus_req.rd_en   = 1'b1;
      bus_req.rd_addr = pic_pkg::PIC_CONFIG_ADDR;

      // Outputs cleared by the first edge with reset held
      @(posedge clk);
      #10;
      check_value("picm_rd_data", picm_rd_data, 32'h0);
      check_value("claim", 32'(claim), 32'h0);
      check_value("mexintpend", 32'(mexintpend), 32'h0);
      check_value("mhwakeup", 32'(mhwakeup), 32'h0);

      repeat (7) @(posedge clk);
      #10;
      bus_req = '0;
      rst_n   = 1'b1;

      foreach (steps[i]) begin
         cur_step = i;
         @(posedge clk);
         #10;
         apply_step(steps[i]);
      end

      errors += pic_top_inst.pic_tb_assert_inst.assert_errors;
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   // Watchdog allows ten cycles per table row plus reset
   initial begin
      wait (table_ready);
      repeat (steps.size() * 10 + 20) @(posedge clk);
      $display("Timeout: the stimulus table did not complete within the cycle limit");
      $display("Testbench failed");
      $finish;
   end

endmodule

// ==== testbench/pic_tb_assert.sv ====
// Concurrent checks on the interrupt controller
// Read data idle rule, claim ID under mexintpend
// Gateway clear pulse width

`timescale 1ns/1ns

module pic_tb_assert (
   input logic                        clk,
   input logic                        rst_n,
   input pic_pkg::pic_bus_req_t       bus_req,
   input logic [31:0]                 picm_rd_data,
   input pic_pkg::pic_claim_t         claim,
   input logic                        mexintpend,
   input logic [pic_pkg::NUM_SRC-1:0] gw_clear
);

   int assert_errors = 0;  // Read by the testbench at the end

   // Read data only in the cycle after a read request
   rd_data_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (picm_rd_data != '0) |-> $past(bus_req.rd_en))
      else begin
         assert_errors++;
         $error("picm_rd_data is nonzero without a read in the cycle before");
      end

   claim_valid: assert property (@(posedge clk) disable iff (!rst_n)
      mexintpend |-> (claim.id != '0))
      else begin
         assert_errors++;
         $error("mexintpend is high while the claim ID is zero");
      end

   clear_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      (gw_clear & $past(gw_clear)) == '0)
      else begin
         assert_errors++;
         $error("gw_clear bit held high for two cycles in a row");
      end

endmodule

bind pic_top pic_tb_assert pic_tb_assert_inst (
   .clk          (clk),
   .rst_n        (rst_n),
   .bus_req      (bus_req),
   .picm_rd_data (picm_rd_data),
   .claim        (claim),
   .mexintpend   (mexintpend),
   .gw_clear     (gw_clear)
);

// ==== rtl/pic_top.sv ====
// Top level of the interrupt controller
// Register block, one gateway per source ID 1 to 15
// Arbiter tree and core notification stage

`timescale 1ns/1ns

module pic_top (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic [pic_pkg::NUM_SRC-1:0]       extintsrc_req,   // Bit 0 unused
   input  pic_pkg::pic_bus_req_t             bus_req,
   input  pic_pkg::pic_core_state_t          core_state,
   output logic [31:0]                       picm_rd_data,
   output pic_pkg::pic_claim_t               claim,
   output logic                              mexintpend,
   output logic                              mhwakeup
);

   logic [pic_pkg::NUM_SRC-1:0][pic_pkg::PRIO_BITS-1:0] prio;
   logic [pic_pkg::NUM_SRC-1:0]                         enable;
   pic_pkg::pic_gw_cfg_t [pic_pkg::NUM_SRC-1:0]         gw_cfg;
   logic [pic_pkg::NUM_SRC-1:0]                         gw_clear;
   logic [pic_pkg::NUM_SRC-1:0]                         pending;
   logic                                                prio_order;
   logic [pic_pkg::PRIO_BITS-1:0]                       sel_prio;
   logic [pic_pkg::ID_BITS-1:0]                         sel_id;

   pic_regs pic_regs_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .bus_req      (bus_req),
      .pending      (pending),
      .prio         (prio),
      .enable       (enable),
      .gw_cfg       (gw_cfg),
      .gw_clear     (gw_clear),
      .prio_order   (prio_order),
      .picm_rd_data (picm_rd_data)
   );

   assign pending[0] = 1'b0;  // Reserved ID

   for (genvar g = 1; g < pic_pkg::NUM_SRC; g++) begin : gen_gw
      pic_gateway pic_gateway_inst (
         .clk     (clk),
         .rst_n   (rst_n),
         .req_in  (extintsrc_req[g]),
         .cfg     (gw_cfg[g]),
         .clear   (gw_clear[g]),
         .pending (pending[g])
      );
   end

   pic_arbiter pic_arbiter_inst (
      .prio       (prio),
      .enable     (enable),
      .pending    (pending),
      .prio_order (prio_order),
      .sel_prio   (sel_prio),
      .sel_id     (sel_id)
   );

   pic_notify pic_notify_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .sel_prio   (sel_prio),
      .sel_id     (sel_id),
      .prio_order (prio_order),
      .core_state (core_state),
      .claim      (claim),
      .mexintpend (mexintpend),
      .mhwakeup   (mhwakeup)
   );

endmodule

// ==== rtl/pic_notify.sv ====
// Core notification stage
// Claim ID and level registers
// Threshold and current-level compare, wake-up detect

`timescale 1ns/1ns

module pic_notify (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [pic_pkg::PRIO_BITS-1:0] sel_prio,
   input  logic [pic_pkg::ID_BITS-1:0]   sel_id,
   input  logic                          prio_order,
   input  pic_pkg::pic_core_state_t      core_state,
   output pic_pkg::pic_claim_t           claim,
   output logic                          mexintpend,
   output logic                          mhwakeup
);

   logic [pic_pkg::PRIO_BITS-1:0] level_in;    // Programmed level of the winner
   logic [pic_pkg::PRIO_BITS-1:0] thresh_eff;
   logic [pic_pkg::PRIO_BITS-1:0] curpl_eff;
   logic [pic_pkg::PRIO_BITS-1:0] max_level;
   logic                          pend_in;
   logic                          wake_in;

   assign level_in = prio_order ? ~sel_prio : sel_prio;

   // Compare in the effective domain of the arbiter
   assign thresh_eff = prio_order ? ~core_state.thresh : core_state.thresh;
   assign curpl_eff  = prio_order ? ~core_state.curpl  : core_state.curpl;

   assign pend_in = (sel_prio > thresh_eff) && (sel_prio > curpl_eff);

   assign max_level = prio_order ? '0 : '1;  // Most urgent programmed value
   assign wake_in   = (level_in == max_level);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         claim      <= '0;
         mexintpend <= 1'b0;
         mhwakeup   <= 1'b0;
      end else begin
         claim.id    <= sel_id;
         claim.level <= level_in;
         mexintpend  <= pend_in;
         mhwakeup    <= wake_in;
      end
   end

endmodule

// ==== rtl/pic_arbiter.sv ====
// Priority arbiter of the interrupt controller
// Enable masking and order inversion per source
// Binary compare-and-select tree, lower ID wins a tie

`timescale 1ns/1ns

module pic_arbiter (
   input  logic [pic_pkg::NUM_SRC-1:0][pic_pkg::PRIO_BITS-1:0] prio,
   input  logic [pic_pkg::NUM_SRC-1:0]                         enable,
   input  logic [pic_pkg::NUM_SRC-1:0]                         pending,
   input  logic                                                prio_order,
   output logic [pic_pkg::PRIO_BITS-1:0]                       sel_prio,   // Effective priority
   output logic [pic_pkg::ID_BITS-1:0]                         sel_id
);

   // One row per tree level, row 0 holds the sources
   logic [pic_pkg::TREE_LEVELS:0][pic_pkg::NUM_SRC-1:0][pic_pkg::PRIO_BITS-1:0] node_p;
   logic [pic_pkg::TREE_LEVELS:0][pic_pkg::NUM_SRC-1:0][pic_pkg::ID_BITS-1:0]   node_id;

   // Keep side a unless b is strictly higher
   function automatic void cmp_sel(
      input  logic [pic_pkg::PRIO_BITS-1:0] a_p,
      input  logic [pic_pkg::ID_BITS-1:0]   a_id,
      input  logic [pic_pkg::PRIO_BITS-1:0] b_p,
      input  logic [pic_pkg::ID_BITS-1:0]   b_id,
      output logic [pic_pkg::PRIO_BITS-1:0] o_p,
      output logic [pic_pkg::ID_BITS-1:0]   o_id
   );
      if (b_p > a_p) begin
         o_p  = b_p;
         o_id = b_id;
      end else begin
         o_p  = a_p;
         o_id = a_id;
      end
   endfunction

   always_comb begin
      node_p  = '0;
      node_id = '0;

      // Leaves
      for (int i = 0; i < pic_pkg::NUM_SRC; i++) begin
         if (pending[i] && enable[i]) begin
            node_p[0][i] = prio_order ? ~prio[i] : prio[i];
         end
         node_id[0][i] = (pic_pkg::ID_BITS)'(i);
      end

      // Lower index is always side a, so ties go to the lower ID
      for (int l = 0; l < pic_pkg::TREE_LEVELS; l++) begin
         for (int m = 0; m < (pic_pkg::NUM_SRC >> (l + 1)); m++) begin
            cmp_sel(node_p[l][2*m],   node_id[l][2*m],
                    node_p[l][2*m+1], node_id[l][2*m+1],
                    node_p[l+1][m],   node_id[l+1][m]);
         end
      end
   end

   assign sel_prio = node_p[pic_pkg::TREE_LEVELS][0];
   assign sel_id   = node_id[pic_pkg::TREE_LEVELS][0];  // ID 0 when nothing pending

endmodule

// ==== rtl/pic_regs.sv ====
// Register block of the interrupt controller
// Bus request capture and address decode
// Priority, enable, gateway config and global order registers
// Gateway clear pulses and read data mux

`timescale 1ns/1ns

module pic_regs (
   input  logic                                                  clk,
   input  logic                                                  rst_n,
   input  pic_pkg::pic_bus_req_t                                 bus_req,
   input  logic [pic_pkg::NUM_SRC-1:0]                           pending,
   output logic [pic_pkg::NUM_SRC-1:0][pic_pkg::PRIO_BITS-1:0]   prio,
   output logic [pic_pkg::NUM_SRC-1:0]                           enable,
   output pic_pkg::pic_gw_cfg_t [pic_pkg::NUM_SRC-1:0]           gw_cfg,
   output logic [pic_pkg::NUM_SRC-1:0]                           gw_clear,
   output logic                                                  prio_order,
   output logic [31:0]                                           picm_rd_data
);

   pic_pkg::pic_bus_req_t req_q;
   pic_pkg::pic_addr_u    raddr;
   pic_pkg::pic_addr_u    waddr;

   logic rd_win;     // Read address inside the window
   logic wr_win;
   logic wr_idx_ok;  // Write targets a real source

   logic prio_wr;
   logic en_wr;
   logic gwcfg_wr;
   logic gwclr_wr;
   logic cfg_wr;

   logic prio_rd;
   logic pend_rd;
   logic en_rd;
   logic gwcfg_rd;
   logic cfg_rd;

   logic [pic_pkg::NUM_SRC-1:0] pend_vec;

   ////////////////////
   // Request capture
   ////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         req_q <= '0;
      end else begin
         req_q <= bus_req;  // Taken every cycle, no stall
      end
   end

   assign raddr.word = req_q.rd_addr;
   assign waddr.word = req_q.wr_addr;

   ////////////////////
   // Address decode
   ////////////////////
   assign rd_win = req_q.rd_en && (raddr.f.page == pic_pkg::PIC_BASE_PAGE) &&
                   (raddr.f.rsvd == '0);
   assign wr_win = req_q.wr_en && (waddr.f.page == pic_pkg::PIC_BASE_PAGE) &&
                   (waddr.f.rsvd == '0);

   assign wr_idx_ok = (waddr.f.index != '0);  // ID 0 has no registers

   assign prio_wr  = wr_win && wr_idx_ok && (waddr.f.region == pic_pkg::REG_PRIORITY);
   assign en_wr    = wr_win && wr_idx_ok && (waddr.f.region == pic_pkg::REG_ENABLE);
   assign gwcfg_wr = wr_win && wr_idx_ok && (waddr.f.region == pic_pkg::REG_GW_CONFIG);
   assign gwclr_wr = wr_win && wr_idx_ok && (waddr.f.region == pic_pkg::REG_GW_CLEAR);
   assign cfg_wr   = req_q.wr_en && (waddr.word == pic_pkg::PIC_CONFIG_ADDR);

   assign prio_rd  = rd_win && (raddr.f.region == pic_pkg::REG_PRIORITY);
   assign en_rd    = rd_win && (raddr.f.region == pic_pkg::REG_ENABLE);
   assign gwcfg_rd = rd_win && (raddr.f.region == pic_pkg::REG_GW_CONFIG);
   assign cfg_rd   = req_q.rd_en && (raddr.word == pic_pkg::PIC_CONFIG_ADDR);

   // Whole pending vector fits in the first word of its page
   assign pend_rd  = rd_win && (raddr.f.region == pic_pkg::REG_PENDING) &&
                     (raddr.f.index == '0);

   ////////////////////
   // Registers
   ////////////////////
   // Entry 0 is never written and stays zero
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         prio       <= '0;
         enable     <= '0;
         gw_cfg     <= '0;
         prio_order <= 1'b0;
      end else begin
         if (prio_wr) begin
            prio[waddr.f.index] <= req_q.wr_data[pic_pkg::PRIO_BITS-1:0];
         end
         if (en_wr) begin
            enable[waddr.f.index] <= req_q.wr_data[0];
         end
         if (gwcfg_wr) begin
            gw_cfg[waddr.f.index] <= req_q.wr_data[1:0];
         end
         if (cfg_wr) begin
            prio_order <= req_q.wr_data[0];  // 1 reverses priority order
         end
      end
   end

   // Clear pulse for one cycle after capture, data is ignored
   always_comb begin
      gw_clear = '0;
      if (gwclr_wr) begin
         gw_clear[waddr.f.index] = 1'b1;
      end
   end

   ////////////////////
   // Read data
   ////////////////////
   assign pend_vec = {pending[pic_pkg::NUM_SRC-1:1], 1'b0};

   // Zero outside a read cycle and for unmapped addresses
   assign picm_rd_data =
      ({32{prio_rd}}  & {{(32-pic_pkg::PRIO_BITS){1'b0}}, prio[raddr.f.index]}) |
      ({32{pend_rd}}  & {{(32-pic_pkg::NUM_SRC){1'b0}}, pend_vec})             |
      ({32{en_rd}}    & {31'b0, enable[raddr.f.index]})                        |
      ({32{gwcfg_rd}} & {30'b0, gw_cfg[raddr.f.index]})                        |
      ({32{cfg_rd}}   & {31'b0, prio_order});

endmodule

// ==== rtl/pic_gateway.sv ====
// Interrupt gateway for one external source
// Two-flop synchronizer, polarity select
// Level or latched-edge pending with software clear

`timescale 1ns/1ns

module pic_gateway (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 req_in,    // Raw asynchronous request
   input  pic_pkg::pic_gw_cfg_t cfg,
   input  logic                 clear,     // One-cycle clear from the register block
   output logic                 pending
);

   logic sync_q1;
   logic sync_q2;
   logic latch_q;
   logic active;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sync_q1 <= 1'b0;
         sync_q2 <= 1'b0;
      end else begin
         sync_q1 <= req_in;
         sync_q2 <= sync_q1;
      end
   end

   assign active = sync_q2 ^ cfg.polarity;  // Active high after polarity

   // Active input wins over a clear in the same cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         latch_q <= 1'b0;
      end else if (cfg.latched && active) begin
         latch_q <= 1'b1;
      end else if (clear) begin
         latch_q <= 1'b0;
      end
   end

   assign pending = active | (cfg.latched & latch_q);

endmodule

// ==== rtl/pic_pkg.sv ====
// Shared definitions for the interrupt controller
// Source count, field widths and register address map
// Register address union, bus request and core-side structs
// Gateway configuration bits

package pic_pkg;

   ////////////////////
   // Sizes
   ////////////////////
   localparam int NUM_SRC     = 16;               // ID 0 reserved
   localparam int ID_BITS     = 8;
   localparam int PRIO_BITS   = 4;
   localparam int TREE_LEVELS = $clog2(NUM_SRC);  // Pairwise compare stages

   ////////////////////
   // Address map
   ////////////////////
   localparam logic [31:0] PIC_BASE_ADDR = 32'hf00c_0000;
   localparam logic [16:0] PIC_BASE_PAGE = PIC_BASE_ADDR[31:15];

   // One 4 KB page per region above the base
   localparam logic [2:0] REG_PRIORITY  = 3'd0;
   localparam logic [2:0] REG_PENDING   = 3'd1;
   localparam logic [2:0] REG_ENABLE    = 3'd2;
   localparam logic [2:0] REG_CONFIG    = 3'd3;
   localparam logic [2:0] REG_GW_CONFIG = 3'd4;
   localparam logic [2:0] REG_GW_CLEAR  = 3'd5;

   // Single global config word
   localparam logic [31:0] PIC_CONFIG_ADDR = {PIC_BASE_PAGE, REG_CONFIG, 12'h000};

   ////////////////////
   // Types
   ////////////////////
   typedef struct packed {
      logic [16:0] page;    // Must equal the base page
      logic [2:0]  region;
      logic [5:0]  rsvd;    // Must be zero
      logic [3:0]  index;   // Source ID
      logic [1:0]  offset;  // Byte offset
   } pic_addr_f_t;

   // Raw word for exact matches, fields for region decode
   typedef union packed {
      logic [31:0] word;
      pic_addr_f_t f;
   } pic_addr_u;

   typedef struct packed {
      logic        rd_en;
      logic        wr_en;
      logic [31:0] rd_addr;
      logic [31:0] wr_addr;
      logic [31:0] wr_data;
   } pic_bus_req_t;

   typedef struct packed {
      logic [PRIO_BITS-1:0] curpl;   // Current priority level
      logic [PRIO_BITS-1:0] thresh;  // Priority threshold
   } pic_core_state_t;

   typedef struct packed {
      logic [ID_BITS-1:0]   id;
      logic [PRIO_BITS-1:0] level;
   } pic_claim_t;

   typedef struct packed {
      logic latched;   // 1 for latched edge
      logic polarity;  // 1 for active low
   } pic_gw_cfg_t;

endpackage
